/* src/cop_pkg.sv */
// ************************************************
// Shared codes for the coprocessor datapath.
// Only custom-1 is accepted. Field positions are
// fixed, with no generated decoder behind them.
// ************************************************
`default_nettype none

package cop_pkg;

    localparam logic [6:0] COP_OPCODE = 7'b0101011; // custom-1

    // Instruction classes
    localparam int CLS_W = 3;
    localparam logic [CLS_W-1:0] CLS_PACKED  = 3'd1;
    localparam logic [CLS_W-1:0] CLS_BITWISE = 3'd2;

    // Subclasses, meaning depends on class
    localparam int SUB_W = 4;
    localparam logic [SUB_W-1:0] SUB_ADD_PX = 4'd0;
    localparam logic [SUB_W-1:0] SUB_SUB_PX = 4'd1;
    localparam logic [SUB_W-1:0] SUB_SLL_PX = 4'd2;
    localparam logic [SUB_W-1:0] SUB_SRL_PX = 4'd3;
    localparam logic [SUB_W-1:0] SUB_ROT_PX = 4'd4;

    localparam logic [SUB_W-1:0] SUB_LLI_CR = 4'd0;
    localparam logic [SUB_W-1:0] SUB_LUI_CR = 4'd1;
    localparam logic [SUB_W-1:0] SUB_BOP_CR = 4'd2;

    // Pack widths, codes 5..7 are illegal
    localparam int PW_W = 3;
    localparam logic [PW_W-1:0] PW_32 = 3'd0;
    localparam logic [PW_W-1:0] PW_16 = 3'd1;
    localparam logic [PW_W-1:0] PW_8  = 3'd2;
    localparam logic [PW_W-1:0] PW_4  = 3'd3;
    localparam logic [PW_W-1:0] PW_2  = 3'd4;

    localparam int NUM_CR = 16;
    localparam int CR_W   = 4;

    // Upper ten bits are either crs2/pw/zero or a 10-bit immediate
    typedef union packed {
        struct packed {
            logic [2:0]       zero;     // Must be 0 for packed ops
            logic [PW_W-1:0]  pw;
            logic [CR_W-1:0]  crs2;
            logic [CR_W-1:0]  crs1;
            logic [SUB_W-1:0] subclass;
            logic [CLS_W-1:0] cls;
            logic [CR_W-1:0]  crd;
            logic [6:0]       opcode;
        } rv;
        struct packed {
            logic [9:0]       imm;
            logic [CR_W-1:0]  crs1;
            logic [SUB_W-1:0] subclass;
            logic [CLS_W-1:0] cls;
            logic [CR_W-1:0]  crd;
            logic [6:0]       opcode;
        } iv;
    } cop_insn_t;

endpackage

`default_nettype wire

/* src/cop_idecode.sv */
// ************************************************
// Combinational decoder, no state.
// Outputs are only meaningful when id_exception
// is low. Disabled classes decode as illegal.
// ************************************************
`default_nettype none

module cop_idecode #(
    parameter bit EN_PACKED  = 1'b1,
    parameter bit EN_BITWISE = 1'b1
) (
    input  wire  [31:0]                id_encoded,
    output logic                       id_exception,
    output logic [cop_pkg::CLS_W-1:0]  id_class,
    output logic [cop_pkg::SUB_W-1:0]  id_subclass,
    output logic [cop_pkg::PW_W-1:0]   id_pw,
    output logic [cop_pkg::CR_W-1:0]   id_crs1,
    output logic [cop_pkg::CR_W-1:0]   id_crs2,
    output logic [cop_pkg::CR_W-1:0]   id_crs3,
    output logic [cop_pkg::CR_W-1:0]   id_crd,
    output logic [9:0]                 id_imm
);

    import cop_pkg::*;

    cop_insn_t insn;

    logic is_packed;
    logic is_bitwise;
    logic crd_in_crs3;

    logic bad_opcode;
    logic bad_class;
    logic bad_subclass;
    logic bad_pack;
    logic disabled;

    assign insn = id_encoded;

    assign is_packed  = insn.rv.cls == CLS_PACKED;
    assign is_bitwise = insn.rv.cls == CLS_BITWISE;

    // Common fields sit at the same place in both views
    assign id_class    = insn.rv.cls;
    assign id_subclass = insn.rv.subclass;
    assign id_crd      = insn.rv.crd;
    assign id_crs1     = insn.rv.crs1;

    // Register view only makes sense for packed ops
    assign id_crs2 = is_packed ? insn.rv.crs2 : '0;
    assign id_pw   = is_packed ? insn.rv.pw   : PW_32;

    // Immediate view for the bitwise class
    assign id_imm = is_bitwise ? insn.iv.imm : '0;

    // LLI, LUI and BOP all modify crd in place
    assign crd_in_crs3 = is_bitwise &&
                         (insn.rv.subclass == SUB_LLI_CR ||
                          insn.rv.subclass == SUB_LUI_CR ||
                          insn.rv.subclass == SUB_BOP_CR);

    assign id_crs3 = crd_in_crs3 ? insn.rv.crd : '0;

    assign bad_opcode = insn.rv.opcode != COP_OPCODE;
    assign bad_class  = !is_packed && !is_bitwise;

    assign bad_subclass = (is_packed  && insn.rv.subclass > SUB_ROT_PX) ||
                          (is_bitwise && insn.rv.subclass > SUB_BOP_CR);

    // Pack width codes above PW_2 and a dirty reserved field
    assign bad_pack = is_packed && (insn.rv.pw > PW_2 || |insn.rv.zero);

    assign disabled = (is_packed  && !EN_PACKED) ||
                      (is_bitwise && !EN_BITWISE);

    assign id_exception = bad_opcode   ||
                          bad_class    ||
                          bad_subclass ||
                          bad_pack     ||
                          disabled;

endmodule

`default_nettype wire

/* src/cop_regfile.sv */
// ************************************************
// 16 x 32 coprocessor registers cleared on reset.
// Reads forward the write port on an index match.
// ************************************************
`default_nettype none

module cop_regfile (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire [cop_pkg::CR_W-1:0]  rd_idx1,
    input  wire [cop_pkg::CR_W-1:0]  rd_idx2,
    input  wire [cop_pkg::CR_W-1:0]  rd_idx3,
    output logic [31:0]              rd_data1,
    output logic [31:0]              rd_data2,
    output logic [31:0]              rd_data3,
    input  wire                      wr_en,
    input  wire [cop_pkg::CR_W-1:0]  wr_idx,
    input  wire [31:0]               wr_data
);

    import cop_pkg::*;

    logic [31:0] regs [NUM_CR];

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write lands at the same edge that samples a dependent instruction
    assign rd_data1 = (wr_en && wr_idx == rd_idx1) ? wr_data : regs[rd_idx1];
    assign rd_data2 = (wr_en && wr_idx == rd_idx2) ? wr_data : regs[rd_idx2];
    assign rd_data3 = (wr_en && wr_idx == rd_idx3) ? wr_data : regs[rd_idx3];

endmodule

`default_nettype wire

/* src/cop_palu.sv */
// ************************************************
// Packed add, sub, shifts and rotate (right).
// Shift amount is rhs[4:0] modulo lane width.
// Illegal pack widths behave as 32-bit lanes.
// ************************************************
`default_nettype none

module cop_palu (
    input  wire  [cop_pkg::SUB_W-1:0] op,
    input  wire  [cop_pkg::PW_W-1:0]  pw,
    input  wire  [31:0]               lhs,
    input  wire  [31:0]               rhs,
    output logic [31:0]               result
);

    import cop_pkg::*;

    logic [4:0]  lw_m1;     // Lane width minus one
    logic [5:0]  lw;
    logic [4:0]  shamt;
    logic [31:0] lane_msb;  // Top bit of every lane
    logic [31:0] keep_sll;  // Bits that stay in lane after a left shift
    logic [31:0] keep_srl;  // Same for a right shift
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] shl;
    logic [31:0] shr;
    logic [31:0] rot;

    always_comb begin
        case (pw)
            PW_32:   lw_m1 = 5'd31;
            PW_16:   lw_m1 = 5'd15;
            PW_8:    lw_m1 = 5'd7;
            PW_4:    lw_m1 = 5'd3;
            PW_2:    lw_m1 = 5'd1;
            default: lw_m1 = 5'd31;
        endcase
    end

    assign lw    = {1'b0, lw_m1} + 6'd1;
    assign shamt = rhs[4:0] & lw_m1;

    always_comb begin
        logic [4:0] pos;
        for (int j = 0; j < 32; j++) begin
            pos         = j[4:0] & lw_m1;   // Bit position inside its lane
            lane_msb[j] = pos == lw_m1;
            keep_sll[j] = pos >= shamt;
            keep_srl[j] = ({1'b0, pos} + {1'b0, shamt}) <= {1'b0, lw_m1};
        end
    end

    // Lane MSBs handled apart so carries and borrows stop at the boundary
    assign sum  = ((lhs & ~lane_msb) + (rhs & ~lane_msb)) ^ ((lhs ^ rhs) & lane_msb);
    assign diff = ((lhs | lane_msb) - (rhs & ~lane_msb)) ^ ((lhs ^ ~rhs) & lane_msb);

    assign shl = (lhs << shamt) & keep_sll;
    assign shr = (lhs >> shamt) & keep_srl;
    assign rot = shr | ((lhs << (lw - {1'b0, shamt})) & ~keep_srl);

    always_comb begin
        case (op)
            SUB_ADD_PX: result = sum;
            SUB_SUB_PX: result = diff;
            SUB_SLL_PX: result = shl;
            SUB_SRL_PX: result = shr;
            SUB_ROT_PX: result = rot;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/cop_execute.sv */
// ************************************************
// Execute stage, purely combinational.
// Illegal classes give zero, they are squashed later.
// ************************************************
`default_nettype none

module cop_execute (
    input  wire  [cop_pkg::CLS_W-1:0] ex_class,
    input  wire  [cop_pkg::SUB_W-1:0] ex_subclass,
    input  wire  [cop_pkg::PW_W-1:0]  ex_pw,
    input  wire  [31:0]               ex_rs1,
    input  wire  [31:0]               ex_rs2,
    input  wire  [31:0]               ex_rs3,    // Old crd for bitwise ops
    input  wire  [9:0]                ex_imm,
    output logic [31:0]               ex_result
);

    import cop_pkg::*;

    logic [31:0] palu_result;
    logic [31:0] bop_result;
    logic [31:0] bitwise_result;

    cop_palu u_palu (
        .op     (ex_subclass),
        .pw     (ex_pw),
        .lhs    (ex_rs1),
        .rhs    (ex_rs2),
        .result (palu_result)
    );

    // Four-entry LUT indexed by {crd bit, crs1 bit}
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            bop_result[i] = ex_imm[{ex_rs3[i], ex_rs1[i]}];
        end
    end

    always_comb begin
        case (ex_subclass)
            SUB_LLI_CR: bitwise_result = {ex_rs3[31:10], ex_imm};
            SUB_LUI_CR: bitwise_result = {ex_imm, ex_rs3[21:0]};
            SUB_BOP_CR: bitwise_result = bop_result;
            default:    bitwise_result = '0;
        endcase
    end

    assign ex_result = (ex_class == CLS_PACKED)  ? palu_result    :
                       (ex_class == CLS_BITWISE) ? bitwise_result : '0;

endmodule

`default_nettype wire

/* src/cop_result.sv */
// ************************************************
// One-cycle result register and write-back.
// Excepting instructions report zero data and
// never write the register file.
// ************************************************
`default_nettype none

module cop_result (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire                      in_exception,
    input  wire [cop_pkg::CR_W-1:0]  in_crd,
    input  wire [31:0]               in_data,
    output logic                     wb_en,
    output logic [cop_pkg::CR_W-1:0] wb_idx,
    output logic [31:0]              wb_data,
    output logic                     result_valid,
    output logic                     result_exception,
    output logic [cop_pkg::CR_W-1:0] result_crd,
    output logic [31:0]              result_data
);

    always_ff @(posedge g_clk) begin
        if (rst) begin
            result_valid     <= 1'b0;
            result_exception <= 1'b0;
        end else begin
            result_valid     <= in_valid;
            result_exception <= in_valid && in_exception;
        end
    end

    // Payload only moves with a valid instruction
    always_ff @(posedge g_clk) begin
        if (in_valid) begin
            result_crd  <= in_crd;
            result_data <= in_exception ? '0 : in_data;
        end
    end

    assign wb_en   = result_valid && !result_exception;
    assign wb_idx  = result_crd;
    assign wb_data = result_data;

endmodule

`default_nettype wire

/* src/cop_top.sv */
// ************************************************
// Coprocessor datapath top level.
// One instruction per cycle, no back-pressure.
// Result shows in the cycle after insn_valid.
// ************************************************
`default_nettype none

module cop_top #(
    parameter bit EN_PACKED  = 1'b1,
    parameter bit EN_BITWISE = 1'b1
) (
    input  wire                       g_clk,
    input  wire                       rst,
    input  wire                       insn_valid,
    input  wire  [31:0]               insn,
    output logic                      result_valid,
    output logic                      result_exception,
    output logic [cop_pkg::CR_W-1:0]  result_crd,
    output logic [31:0]               result_data
);

    import cop_pkg::*;

    logic             id_exception;
    logic [CLS_W-1:0] id_class;
    logic [SUB_W-1:0] id_subclass;
    logic [PW_W-1:0]  id_pw;
    logic [CR_W-1:0]  id_crs1;
    logic [CR_W-1:0]  id_crs2;
    logic [CR_W-1:0]  id_crs3;
    logic [CR_W-1:0]  id_crd;
    logic [9:0]       id_imm;

    logic [31:0]      rs1_data;
    logic [31:0]      rs2_data;
    logic [31:0]      rs3_data;
    logic [31:0]      ex_result;

    logic             wb_en;
    logic [CR_W-1:0]  wb_idx;
    logic [31:0]      wb_data;

    cop_idecode #(
        .EN_PACKED  (EN_PACKED),
        .EN_BITWISE (EN_BITWISE)
    ) u_idecode (
        .id_encoded   (insn),
        .id_exception (id_exception),
        .id_class     (id_class),
        .id_subclass  (id_subclass),
        .id_pw        (id_pw),
        .id_crs1      (id_crs1),
        .id_crs2      (id_crs2),
        .id_crs3      (id_crs3),
        .id_crd       (id_crd),
        .id_imm       (id_imm)
    );

    cop_regfile u_regfile (
        .g_clk    (g_clk),
        .rst      (rst),
        .rd_idx1  (id_crs1),
        .rd_idx2  (id_crs2),
        .rd_idx3  (id_crs3),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data),
        .rd_data3 (rs3_data),
        .wr_en    (wb_en),
        .wr_idx   (wb_idx),
        .wr_data  (wb_data)
    );

    cop_execute u_execute (
        .ex_class    (id_class),
        .ex_subclass (id_subclass),
        .ex_pw       (id_pw),
        .ex_rs1      (rs1_data),
        .ex_rs2      (rs2_data),
        .ex_rs3      (rs3_data),
        .ex_imm      (id_imm),
        .ex_result   (ex_result)
    );

    cop_result u_result (
        .g_clk            (g_clk),
        .rst              (rst),
        .in_valid         (insn_valid),
        .in_exception     (id_exception),
        .in_crd           (id_crd),
        .in_data          (ex_result),
        .wb_en            (wb_en),
        .wb_idx           (wb_idx),
        .wb_data          (wb_data),
        .result_valid     (result_valid),
        .result_exception (result_exception),
        .result_crd       (result_crd),
        .result_data      (result_data)
    );

endmodule

`default_nettype wire

/* tb/cop_tb.sv */
// ************************************************
// Testbench for cop_top with both classes enabled.
// Shadow registers model the datapath. Rotate is
// modeled as a right rotate within each lane.
// cr14 and cr15 hold shift amounts for the shift tests.
// ************************************************
`default_nettype none

module cop_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cop_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RST_CYCLES    = 5;
    localparam int LOAD_INSNS    = 2 * NUM_CR;
    localparam int ARITH_PER     = 6;
    localparam int ARITH_INSNS   = 5 * 2 * ARITH_PER;
    localparam int SHIFT_PER     = 6;
    localparam int SHIFT_INSNS   = 2 + 5 * 3 * SHIFT_PER;
    localparam int BIT_PER       = 8;
    localparam int BIT_INSNS     = 3 * BIT_PER;
    localparam int ILLEGAL_INSNS = 2 * 15;      // Each illegal one is followed by a readback
    localparam int CHAIN_INSNS   = 40;
    localparam int NUM_INSNS     = 1 + LOAD_INSNS + BIT_INSNS + ARITH_INSNS + SHIFT_INSNS +
                                   ILLEGAL_INSNS + CHAIN_INSNS;
    localparam int IDLE_CYCLES   = 27;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES + NUM_INSNS + 20;

    logic              g_clk;
    logic              rst;
    logic              insn_valid;
    logic [31:0]       insn;
    wire               result_valid;
    wire               result_exception;
    wire  [CR_W-1:0]   result_crd;
    wire  [31:0]       result_data;

    logic [31:0]       shadow [NUM_CR];     // Expected register contents
    bit                exp_exc_q [$];
    logic [CR_W-1:0]   exp_crd_q [$];
    logic [31:0]       exp_data_q [$];

    int                errors = 0;
    int                checks = 0;
    integer            seed = 32'hd917_f934;
    bit                check_en = 1'b0;
    bit                issued_last = 1'b0;

    cop_top #(
        .EN_PACKED  (1'b1),
        .EN_BITWISE (1'b1)
    ) dut0 (
        .g_clk            (g_clk),
        .rst              (rst),
        .insn_valid       (insn_valid),
        .insn             (insn),
        .result_valid     (result_valid),
        .result_exception (result_exception),
        .result_crd       (result_crd),
        .result_data      (result_data)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Lane-wise reference, lane width is 32 >> pw
    function automatic logic [31:0] model_packed(input logic [3:0] op, input logic [2:0] pw,
                                                 input logic [31:0] a, input logic [31:0] b);
        int          w;
        int          sh;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        logic [31:0] r;
        w    = 32 >> pw;
        mask = (64'd1 << w) - 64'd1;
        sh   = b[4:0] % w;
        r    = '0;
        for (int l = 0; l < 32 / w; l++) begin
            la = (a >> (l * w)) & mask;
            lb = (b >> (l * w)) & mask;
            case (op)
                SUB_ADD_PX: lr = la + lb;
                SUB_SUB_PX: lr = la - lb;
                SUB_SLL_PX: lr = la << sh;
                SUB_SRL_PX: lr = la >> sh;
                default:    lr = (la >> sh) | (la << (w - sh));
            endcase
            r = r | ((lr & mask) << (l * w));
        end
        return r;
    endfunction

    function automatic logic [31:0] model_bitwise(input logic [3:0] sub, input logic [31:0] old,
                                                  input logic [31:0] rs1, input logic [9:0] imm);
        logic [31:0] r;
        case (sub)
            SUB_LLI_CR: r = {old[31:10], imm};
            SUB_LUI_CR: r = {imm, old[21:0]};
            default: begin
                for (int i = 0; i < 32; i++) begin
                    r[i] = imm[2 * old[i] + rs1[i]];   // LUT in imm[3:0]
                end
            end
        endcase
        return r;
    endfunction

    function automatic logic [31:0] make_packed(input logic [3:0] sub, input logic [2:0] pw,
                                                input logic [3:0] crd, input logic [3:0] crs1,
                                                input logic [3:0] crs2);
        return {3'b000, pw, crs2, crs1, sub, CLS_PACKED, crd, COP_OPCODE};
    endfunction

    function automatic logic [31:0] make_bitwise(input logic [3:0] sub, input logic [3:0] crd,
                                                 input logic [3:0] crs1, input logic [9:0] imm);
        return {imm, crs1, sub, CLS_BITWISE, crd, COP_OPCODE};
    endfunction

    task automatic present(input logic [31:0] word, input bit exc,
                           input logic [CR_W-1:0] crd, input logic [31:0] data);
        @(negedge g_clk);
        insn_valid = 1'b1;
        insn       = word;
        exp_exc_q.push_back(exc);
        exp_crd_q.push_back(crd);
        exp_data_q.push_back(data);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge g_clk);
            insn_valid = 1'b0;
            insn       = $random(seed);    // Garbage on the bus must be ignored
        end
    endtask

    task automatic issue_packed(input logic [3:0] op, input logic [2:0] pw, input logic [3:0] crd,
                                input logic [3:0] crs1, input logic [3:0] crs2);
        logic [31:0] exp;
        exp         = model_packed(op, pw, shadow[crs1], shadow[crs2]);
        shadow[crd] = exp;
        present(make_packed(op, pw, crd, crs1, crs2), 1'b0, crd, exp);
    endtask

    task automatic issue_bitwise(input logic [3:0] sub, input logic [3:0] crd,
                                 input logic [3:0] crs1, input logic [9:0] imm);
        logic [31:0] exp;
        exp         = model_bitwise(sub, shadow[crd], shadow[crs1], imm);
        shadow[crd] = exp;
        present(make_bitwise(sub, crd, crs1, imm), 1'b0, crd, exp);
    endtask

    // BOP with LUT 1100 copies crd onto itself
    task automatic check_reg(input logic [3:0] idx);
        issue_bitwise(SUB_BOP_CR, idx, idx, 10'b1100);
    endtask

    task automatic present_illegal(input logic [31:0] word);
        present(word, 1'b1, word[10:7], 32'h0);
        check_reg(word[10:7]);
    endtask

    // Result checker, DUT outputs seen before this edge's updates
    always @(posedge g_clk) begin
        bit              e_exc;
        logic [CR_W-1:0] e_crd;
        logic [31:0]     e_data;
        if (check_en) begin
            checks++;
            assert (result_valid === issued_last)
                else flag_error($sformatf("result_valid is %b, expected %b",
                                          result_valid, issued_last));
            if (result_valid !== 1'b1) begin
                assert (result_exception === 1'b0)
                    else flag_error("result_exception high without result_valid");
            end else if (exp_exc_q.size() == 0) begin
                errors++;
                $display("A result was reported with no instruction outstanding");
            end else begin
                e_exc  = exp_exc_q.pop_front();
                e_crd  = exp_crd_q.pop_front();
                e_data = exp_data_q.pop_front();
                checks += 3;
                assert (result_exception === e_exc)
                    else flag_error($sformatf("result_exception is %b, expected %b",
                                              result_exception, e_exc));
                assert (result_crd === e_crd)
                    else flag_error($sformatf("result_crd is %0d, expected %0d",
                                              result_crd, e_crd));
                assert (result_data === e_data)
                    else flag_error($sformatf("result_data is %h, expected %h",
                                              result_data, e_data));
            end
        end
        issued_last = insn_valid && !rst;
        if (rst) begin
            check_en = 1'b1;
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] base;
        logic [3:0]  prev;
        logic [3:0]  nxt;
        logic [3:0]  rs2;
        rst        = 1'b1;
        insn_valid = 1'b0;
        insn       = '0;
        for (int i = 0; i < NUM_CR; i++) begin
            shadow[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        rst = 1'b0;
        idle(4);

        check_reg(4'd5);        // Cleared by reset
        idle(3);

        for (int r = 0; r < NUM_CR; r++) begin
            v = $random(seed);
            issue_bitwise(SUB_LLI_CR, r[3:0], $random(seed), v[9:0]);
            issue_bitwise(SUB_LUI_CR, r[3:0], $random(seed), v[31:22]);
        end
        idle(3);

        // Bitwise ops read old crd contents
        for (int s = 0; s < 3; s++) begin
            repeat (BIT_PER) begin
                issue_bitwise(s[3:0], $random(seed), $random(seed), $random(seed));
            end
        end
        idle(3);

        for (int p = 0; p < 5; p++) begin
            for (int o = 0; o < 2; o++) begin
                repeat (ARITH_PER) begin
                    issue_packed(o[3:0], p[2:0], $random(seed), $random(seed), $random(seed));
                end
            end
        end
        idle(3);

        // Amounts 29 and 18 reach past most lane widths
        issue_bitwise(SUB_LLI_CR, 4'd14, 4'd0, 10'd29);
        issue_bitwise(SUB_LLI_CR, 4'd15, 4'd0, 10'd18);
        for (int p = 0; p < 5; p++) begin
            for (int o = 2; o < 5; o++) begin
                for (int k = 0; k < SHIFT_PER; k++) begin
                    rs2 = (k % 3 == 0) ? 4'd14 : (k % 3 == 1) ? 4'd15 : $random(seed);
                    issue_packed(o[3:0], p[2:0], {$random(seed)} % 14, $random(seed), rs2);
                end
            end
        end
        idle(3);

        base = make_packed(SUB_ADD_PX, PW_8, $random(seed), 4'd1, 4'd2);
        present_illegal({base[31:7], 7'b0001011});          // custom-0
        for (int c = 0; c < 8; c++) begin
            if (c != 1 && c != 2) begin
                present_illegal({base[31:14], c[2:0], base[10:0]});
            end
        end
        present_illegal(make_packed(4'd5, PW_8, $random(seed), 4'd1, 4'd2));
        present_illegal(make_packed(4'd15, PW_16, $random(seed), 4'd3, 4'd4));
        present_illegal(make_bitwise(4'd3, $random(seed), 4'd1, $random(seed)));
        for (int p = 5; p < 8; p++) begin
            present_illegal(make_packed(SUB_ADD_PX, p[2:0], $random(seed), 4'd1, 4'd2));
        end
        present_illegal(make_packed(SUB_SUB_PX, PW_4, $random(seed), 4'd1, 4'd2) | 32'h2000_0000);
        present_illegal(make_packed(SUB_SLL_PX, PW_2, $random(seed), 4'd1, 4'd2) | 32'h8000_0000);
        idle(3);

        // Each instruction reads the previous destination
        prev = 4'd0;
        repeat (CHAIN_INSNS) begin
            nxt = $random(seed);
            if ({$random(seed)} % 4 == 0) begin
                issue_bitwise(SUB_BOP_CR, nxt, prev, $random(seed));
            end else begin
                issue_packed({$random(seed)} % 5, {$random(seed)} % 5, nxt, prev, $random(seed));
            end
            prev = nxt;
        end
        idle(4);

        if (exp_exc_q.size() != 0) begin
            errors++;
            $display("%0d instructions never produced a result", exp_exc_q.size());
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/cop_pkg.sv
src/cop_idecode.sv
src/cop_regfile.sv
src/cop_palu.sv
src/cop_execute.sv
src/cop_result.sv
src/cop_top.sv
tb/cop_tb.sv
